//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= mpmc_core.f
RTL_TOP   ?= mpmc_core
TB_TOP    ?= mpmc_core_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- common/mpmc_app_if.sv
`default_nettype none

`include "mpmc_params.svh"

// DDR-style application port between controller and memory
interface mpmc_app_if;

	// Command channel, accepted when app_en and app_rdy are both high
	logic                    app_en;
	logic                    app_wr;
	logic [`MPMC_ADDR_W-1:0] app_addr;
	logic                    app_rdy;

	// Write data channel
	logic                    app_wdf_wren;
	logic [`MPMC_DATA_W-1:0] app_wdf_data;
	logic                    app_wdf_rdy;

	// Read data returns in order, one beat per valid cycle
	logic [`MPMC_DATA_W-1:0] app_rd_data;
	logic                    app_rd_data_valid;

	modport ctrl (
		output app_en, app_wr, app_addr, app_wdf_wren, app_wdf_data,
		input  app_rdy, app_wdf_rdy, app_rd_data, app_rd_data_valid
	);

	// The FSM only watches the readies
	modport ctrl_obs (input app_rdy, app_wdf_rdy);

	modport mem_side (
		input  app_en, app_wr, app_addr, app_wdf_wren, app_wdf_data,
		output app_rdy, app_wdf_rdy, app_rd_data, app_rd_data_valid
	);

endinterface

`default_nettype wire

//--- common/mpmc_bus_pkg.sv
`default_nettype none

`include "mpmc_params.svh"

package mpmc_bus_pkg;

	// ========================================
	// Request opcodes
	// ========================================
	typedef enum logic [3:0] {
		CMD_LOAD  = 4'd0,
		CMD_STORE = 4'd1,
		// Read-modify-write atomics, all return the old word
		CMD_ADD   = 4'd2,
		CMD_AND   = 4'd3,
		CMD_OR    = 4'd4,
		CMD_EOR   = 4'd5,
		CMD_MIN   = 4'd6,
		CMD_MAX   = 4'd7,
		CMD_MINU  = 4'd8,
		CMD_MAXU  = 4'd9,
		CMD_ASL   = 4'd10,
		CMD_LSR   = 4'd11
	} opcode_t;

	// One queued command, 54 bits
	typedef struct packed {
		opcode_t                 op;
		logic [`MPMC_ADDR_W-1:0] addr;
		// Store value or ALU operand
		logic [`MPMC_DATA_W-1:0] data;
		// Beats minus one, only loads use more than one
		logic [1:0]              burst;
	} cmd_t;

endpackage

`default_nettype wire

//--- common/mpmc_ctrl_pkg.sv
`default_nettype none

package mpmc_ctrl_pkg;

	// Controller FSM states
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		PRESET1      = 4'd1,
		PRESET2      = 4'd2,
		PRESET3      = 4'd3,
		WRITE_DATA0  = 4'd4,
		WRITE_DATA1  = 4'd5,
		READ_DATA0   = 4'd6,
		READ_DATA2   = 4'd7,
		// Staged ALU of an atomic
		ALU1         = 4'd8,
		ALU2         = 4'd9,
		ALU3         = 4'd10,
		ALU4         = 4'd11,
		WRITE_TRAMP1 = 4'd12,
		WAIT_NACK    = 4'd13
	} state_t;

endpackage

`default_nettype wire

//--- common/mpmc_params.svh
`ifndef MPMC_PARAMS_SVH
`define MPMC_PARAMS_SVH

// Word address width, one address per data word
`define MPMC_ADDR_W 16

// Width of a memory word and of the ALU
`define MPMC_DATA_W 32

// Number of queued commands
`define MPMC_FIFO_DEPTH 4

// Cycles away from IDLE before the transaction is abandoned
`define MPMC_TIMEOUT 64

`endif

//--- datapath/mpmc_datapath.sv
`default_nettype none

`include "mpmc_params.svh"

module mpmc_datapath (
	input  wire                          clk,
	input  wire                          rst,
	input  mpmc_ctrl_pkg::state_t        state,
	input  wire                          select_next,
	input  mpmc_bus_pkg::cmd_t           head,
	output mpmc_bus_pkg::opcode_t        cur_op,
	output logic [1:0]                   burst,
	output logic                         req_beat,
	output logic                         resp_beat,
	output logic                         resp_valid,
	output logic [`MPMC_DATA_W-1:0]      resp_data,
	mpmc_app_if.ctrl                     app
);

	localparam int W = `MPMC_DATA_W;

	mpmc_bus_pkg::cmd_t      cur;
	logic [`MPMC_ADDR_W-1:0] addr;
	logic [W-1:0]            rd_word;
	logic [W-1:0]            wr_data;
	logic [W-1:0]            alu_s1;
	logic [W-1:0]            alu_s2;
	logic [W-1:0]            alu_s3;
	logic                    rd_issue;
	logic                    wr_issue;
	logic                    rd_phase;

	// ========================================
	// ALU
	// ========================================
	// a is the old memory word, b the command operand
	function automatic logic [W-1:0] alu_eval(
		input mpmc_bus_pkg::opcode_t op,
		input logic [W-1:0]          a,
		input logic [W-1:0]          b
	);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			mpmc_bus_pkg::CMD_ADD:  alu_eval = a + b;
			mpmc_bus_pkg::CMD_AND:  alu_eval = a & b;
			mpmc_bus_pkg::CMD_OR:   alu_eval = a | b;
			mpmc_bus_pkg::CMD_EOR:  alu_eval = a ^ b;
			mpmc_bus_pkg::CMD_MIN:  alu_eval = ($signed(a) < $signed(b)) ? a : b;
			mpmc_bus_pkg::CMD_MAX:  alu_eval = ($signed(a) > $signed(b)) ? a : b;
			mpmc_bus_pkg::CMD_MINU: alu_eval = (a < b) ? a : b;
			mpmc_bus_pkg::CMD_MAXU: alu_eval = (a > b) ? a : b;
			mpmc_bus_pkg::CMD_ASL:  alu_eval = a << sh;
			mpmc_bus_pkg::CMD_LSR:  alu_eval = a >> sh;
			default:                alu_eval = b;
		endcase
	endfunction

	// Current command, burst forced to one beat for all but loads
	always_ff @(posedge clk) begin
		if (select_next) begin
			cur <= head;
			if (head.op != mpmc_bus_pkg::CMD_LOAD)
				cur.burst <= 2'd0;
		end
	end

	assign cur_op = cur.op;
	assign burst  = cur.burst;

	// ========================================
	// Port drive
	// ========================================
	assign rd_issue = state == mpmc_ctrl_pkg::READ_DATA0;
	assign wr_issue = state == mpmc_ctrl_pkg::WRITE_DATA1;

	assign app.app_en       = rd_issue || wr_issue;
	assign app.app_wr       = wr_issue;
	assign app.app_addr     = addr;
	assign app.app_wdf_wren = wr_issue;
	assign app.app_wdf_data = wr_data;

	// Only read requests count as burst beats
	assign req_beat  = rd_issue && app.app_rdy;
	assign resp_beat = app.app_rd_data_valid;

	// Address steps per accepted read beat
	// Atomic write-back returns to the base address
	always_ff @(posedge clk) begin
		if (select_next)
			addr <= head.addr;
		else if (state == mpmc_ctrl_pkg::WRITE_TRAMP1)
			addr <= cur.addr;
		else if (req_beat)
			addr <= addr + 1'b1;
	end

	// ========================================
	// Read data and responses
	// ========================================
	// Beats can arrive while later ones are still being issued
	assign rd_phase = rd_issue || (state == mpmc_ctrl_pkg::READ_DATA2);

	always_ff @(posedge clk) begin
		if (app.app_rd_data_valid)
			rd_word <= app.app_rd_data;
	end

	always_ff @(posedge clk) begin
		if (rst)
			resp_valid <= 1'b0;
		else
			resp_valid <= app.app_rd_data_valid && rd_phase;
	end

	// rd_word doubles as the old value of an atomic
	assign resp_data = rd_word;

	// Staged ALU, ALU2 and ALU3 leave room for a deeper unit
	always_ff @(posedge clk) begin
		case (state)
			mpmc_ctrl_pkg::ALU1: alu_s1 <= alu_eval(cur.op, rd_word, cur.data);
			mpmc_ctrl_pkg::ALU2: alu_s2 <= alu_s1;
			mpmc_ctrl_pkg::ALU3: alu_s3 <= alu_s2;
			default: ;
		endcase
	end

	// Write-back value, store data or the ALU result
	always_ff @(posedge clk) begin
		if (select_next)
			wr_data <= head.data;
		else if (state == mpmc_ctrl_pkg::ALU4)
			wr_data <= alu_s3;
	end

endmodule

`default_nettype wire

//--- mpmc_core.f
+incdir+common
common/mpmc_bus_pkg.sv
common/mpmc_ctrl_pkg.sv
common/mpmc_app_if.sv
verilog/mpmc_cmd_fifo.sv
verilog/mpmc_state_machine.sv
verilog/mpmc_burst_counter.sv
verilog/mpmc_timeout_timer.sv
datapath/mpmc_datapath.sv
verilog/mpmc_core.sv
verification/mpmc_mem_model.sv
verification/mpmc_core_tb.sv

//--- verification/mpmc_core_tb.sv
`default_nettype none

`include "mpmc_params.svh"

module mpmc_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int AW = `MPMC_ADDR_W;
	localparam int DW = `MPMC_DATA_W;
	localparam int WAIT_LIMIT = 400;

	logic                  clk;
	logic                  rst;
	logic                  calib_complete;
	logic                  cmd_valid;
	mpmc_bus_pkg::opcode_t cmd_op;
	logic [AW-1:0]         cmd_addr;
	logic [DW-1:0]         cmd_data;
	logic [1:0]            cmd_burst;
	logic                  cmd_full;
	logic                  resp_valid;
	logic [DW-1:0]         resp_data;
	logic                  timeout_err;
	logic                  app_en;
	logic                  app_wr;
	logic [AW-1:0]         app_addr;
	logic                  app_rdy;
	logic                  app_wdf_wren;
	logic [DW-1:0]         app_wdf_data;
	logic                  app_wdf_rdy;
	logic [DW-1:0]         app_rd_data;
	logic                  app_rd_data_valid;

	// Memory model controls
	logic                  stall;
	logic                  rdy_rand;
	logic                  wdf_rdy_rand;
	logic [1:0]            lat_sel;
	logic [5:0]            mem_bits;

	// Reference model and bookkeeping
	logic [23:0]           lfsr;
	logic [DW-1:0]         shadow [256];
	logic [DW-1:0]         exp_q [$];
	int                    errors;
	int                    checks;
	int                    tests;
	int                    writes_seen;
	int                    writes_exp;
	int                    to_seen;

	mpmc_core dut0 (
		.clk(clk), .rst(rst), .calib_complete(calib_complete),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
		.cmd_data(cmd_data), .cmd_burst(cmd_burst), .cmd_full(cmd_full),
		.resp_valid(resp_valid), .resp_data(resp_data), .timeout_err(timeout_err),
		.app_en(app_en), .app_wr(app_wr), .app_addr(app_addr), .app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
		.app_wdf_rdy(app_wdf_rdy), .app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid)
	);

	mpmc_mem_model mem0 (
		.clk(clk), .rst(rst), .stall(stall), .rdy_rand(rdy_rand),
		.wdf_rdy_rand(wdf_rdy_rand), .lat_sel(lat_sel), .app_en(app_en),
		.app_wr(app_wr), .app_addr(app_addr), .app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
		.app_wdf_rdy(app_wdf_rdy), .app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid)
	);

	always #2 clk = ~clk;

	// ========================================
	// Random numbers
	// ========================================
	// Fibonacci LFSR, taps 24 23 22 17
	function automatic logic [23:0] lfsr_step(input logic [23:0] s);
		return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Drawn on the falling edge so it never races the stimulus
	always @(negedge clk)
		mem_bits = 6'(rand_bits(6));

	// Readies high three cycles in four
	always @(posedge clk) begin
		#1;
		rdy_rand     <= mem_bits[0] | mem_bits[1];
		wdf_rdy_rand <= mem_bits[2] | mem_bits[3];
		lat_sel      <= mem_bits[5:4];
	end

	// ========================================
	// Reference ALU
	// ========================================
	function automatic logic [DW-1:0] alu_ref(
		input mpmc_bus_pkg::opcode_t op,
		input logic [DW-1:0]         old,
		input logic [DW-1:0]         opd
	);
		int so;
		int sd;
		so = old;
		sd = opd;
		case (op)
			mpmc_bus_pkg::CMD_ADD:  return old + opd;
			mpmc_bus_pkg::CMD_AND:  return old & opd;
			mpmc_bus_pkg::CMD_OR:   return old | opd;
			mpmc_bus_pkg::CMD_EOR:  return old ^ opd;
			mpmc_bus_pkg::CMD_MIN:  return (so <= sd) ? old : opd;
			mpmc_bus_pkg::CMD_MAX:  return (so >= sd) ? old : opd;
			mpmc_bus_pkg::CMD_MINU: return (old <= opd) ? old : opd;
			mpmc_bus_pkg::CMD_MAXU: return (old >= opd) ? old : opd;
			// Only the low five operand bits give the shift
			mpmc_bus_pkg::CMD_ASL:  return old << opd[4:0];
			mpmc_bus_pkg::CMD_LSR:  return old >> opd[4:0];
			default:                return opd;
		endcase
	endfunction

	// ========================================
	// Output checks, sampled mid-cycle
	// ========================================
	always @(negedge clk) begin
		logic [DW-1:0] want;
		if (!rst) begin
			if (!calib_complete) begin
				checks++;
				assert (!app_en && !resp_valid) else begin
					$display("app port or response active before calibration");
					errors++;
				end
			end
			if (resp_valid) begin
				checks++;
				assert (exp_q.size() > 0) else begin
					$display("response arrived with no command expecting one");
					errors++;
				end
				if (exp_q.size() > 0) begin
					want = exp_q.pop_front();
					assert (resp_data == want) else begin
						$display("FAIL resp_data got %h expected %h", resp_data, want);
						errors++;
					end
				end
			end
			if (timeout_err)
				to_seen++;
			if (app_en && app_wr && app_rdy && app_wdf_wren && app_wdf_rdy)
				writes_seen++;
		end
	end

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	// Push one command once the FIFO has room
	task automatic send(
		input mpmc_bus_pkg::opcode_t op,
		input logic [AW-1:0]         addr,
		input logic [DW-1:0]         data,
		input logic [1:0]            burst
	);
		int n;
		n = 0;
		while (cmd_full && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			$display("command FIFO never left the full state");
			errors++;
		end
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_addr  = addr;
		cmd_data  = data;
		cmd_burst = burst;
		tick();
		cmd_valid = 1'b0;
	endtask

	// Fold a command into the shadow memory, then send it
	task automatic issue(
		input mpmc_bus_pkg::opcode_t op,
		input logic [AW-1:0]         addr,
		input logic [DW-1:0]         data,
		input logic [1:0]            burst
	);
		logic [7:0]    idx;
		logic [DW-1:0] old;
		idx = addr[7:0];
		if (op == mpmc_bus_pkg::CMD_LOAD) begin
			for (int i = 0; i <= int'(burst); i++)
				exp_q.push_back(shadow[idx + 8'(i)]);
		end else if (op == mpmc_bus_pkg::CMD_STORE) begin
			shadow[idx] = data;
			writes_exp++;
		end else begin
			// Atomics answer with the old word
			old = shadow[idx];
			exp_q.push_back(old);
			shadow[idx] = alu_ref(op, old, data);
			writes_exp++;
		end
		send(op, addr, data, burst);
	endtask

	// Wait until every response and write-back has been seen
	task automatic drain(input string name);
		int n;
		n = 0;
		while ((exp_q.size() > 0 || writes_seen != writes_exp) && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			$display("%s timed out with commands outstanding", name);
			errors++;
		end
		// WAIT_NACK and the return to IDLE
		repeat (3) tick();
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic calib_hold_test();
		int            e0;
		logic [AW-1:0] a;
		e0 = errors;
		a  = AW'(rand_bits(AW));
		issue(mpmc_bus_pkg::CMD_STORE, a, rand_bits(DW), 2'd0);
		issue(mpmc_bus_pkg::CMD_LOAD, a, '0, 2'd0);
		repeat (20) tick();
		calib_complete = 1'b1;
		drain("calib_hold");
		report("calib_hold", e0);
	endtask

	task automatic store_load_test();
		int            e0;
		logic [AW-1:0] a;
		e0 = errors;
		for (int k = 0; k < 6; k++) begin
			a = AW'(rand_bits(AW));
			issue(mpmc_bus_pkg::CMD_STORE, a, rand_bits(DW), 2'd0);
			issue(mpmc_bus_pkg::CMD_LOAD, a, '0, 2'd0);
		end
		drain("store_load");
		report("store_load", e0);
	endtask

	task automatic burst_test();
		int e0;
		e0 = errors;
		for (int k = 0; k < 6; k++)
			issue(mpmc_bus_pkg::CMD_LOAD, AW'(rand_bits(AW)), '0, 2'(1 + rand_bits(2) % 3));
		drain("burst_load");
		report("burst_load", e0);
	endtask

	task automatic atomic_test();
		int                    e0;
		logic [AW-1:0]         a;
		mpmc_bus_pkg::opcode_t op;
		e0 = errors;
		for (int k = 2; k <= 11; k++) begin
			op = mpmc_bus_pkg::opcode_t'(k);
			a  = AW'(rand_bits(AW));
			// A nonzero burst here must be ignored
			issue(op, a, rand_bits(DW), 2'(rand_bits(2)));
			issue(mpmc_bus_pkg::CMD_LOAD, a, '0, 2'd0);
		end
		drain("atomics");
		report("atomics", e0);
	endtask

	task automatic fifo_full_test();
		int            e0;
		logic [AW-1:0] a;
		e0 = errors;
		calib_complete = 1'b0;
		a = AW'(rand_bits(AW));
		issue(mpmc_bus_pkg::CMD_STORE, a, rand_bits(DW), 2'd0);
		issue(mpmc_bus_pkg::CMD_LOAD, a, '0, 2'd2);
		issue(mpmc_bus_pkg::CMD_ADD, a, rand_bits(DW), 2'd0);
		issue(mpmc_bus_pkg::CMD_LOAD, a, '0, 2'd0);
		checks++;
		assert (cmd_full) else begin
			$display("FAIL cmd_full got %h expected %h", cmd_full, 1'b1);
			errors++;
		end
		calib_complete = 1'b1;
		drain("fifo_full");
		report("fifo_full", e0);
	endtask

	task automatic timeout_test();
		int            e0;
		int            t0;
		int            n;
		logic [AW-1:0] a;
		e0 = errors;
		t0 = to_seen;
		a  = AW'(rand_bits(AW));
		stall = 1'b1;
		// Abandoned load, nothing is expected back
		send(mpmc_bus_pkg::CMD_LOAD, a, '0, 2'd0);
		n = 0;
		while (to_seen == t0 && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			$display("no timeout_err pulse while the memory was stalled");
			errors++;
		end
		repeat (8) tick();
		checks++;
		assert (to_seen == t0 + 1) else begin
			$display("timeout_err pulsed %0d times for one hung load", to_seen - t0);
			errors++;
		end
		stall = 1'b0;
		issue(mpmc_bus_pkg::CMD_LOAD, a, '0, 2'd1);
		drain("timeout");
		report("timeout", e0);
	endtask

	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		calib_complete = 1'b0;
		cmd_valid      = 1'b0;
		cmd_op         = mpmc_bus_pkg::CMD_LOAD;
		cmd_addr       = '0;
		cmd_data       = '0;
		cmd_burst      = '0;
		stall          = 1'b0;
		rdy_rand       = 1'b0;
		wdf_rdy_rand   = 1'b0;
		lat_sel        = '0;
		mem_bits       = '0;
		lfsr           = 24'd93244;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		writes_seen    = 0;
		writes_exp     = 0;
		to_seen        = 0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		// Shadow starts from the model's power-up contents
		for (int i = 0; i < 256; i++)
			shadow[i] = mem0.mem[i];
		calib_hold_test();
		store_load_test();
		burst_test();
		atomic_test();
		fifo_full_test();
		timeout_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/mpmc_mem_model.sv
`default_nettype none

`include "mpmc_params.svh"

module mpmc_mem_model (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      stall,
	input  wire                      rdy_rand,
	input  wire                      wdf_rdy_rand,
	input  wire [1:0]                lat_sel,
	input  wire                      app_en,
	input  wire                      app_wr,
	input  wire [`MPMC_ADDR_W-1:0]   app_addr,
	output logic                     app_rdy,
	input  wire                      app_wdf_wren,
	input  wire [`MPMC_DATA_W-1:0]   app_wdf_data,
	output logic                     app_wdf_rdy,
	output logic [`MPMC_DATA_W-1:0]  app_rd_data,
	output logic                     app_rd_data_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [`MPMC_DATA_W-1:0] mem [256];
	logic [`MPMC_DATA_W-1:0] data_q [$];
	int                      due_q [$];
	int                      cyc;
	int                      last_due;

	// Readies come straight from the random back-pressure
	assign app_rdy     = rdy_rand;
	assign app_wdf_rdy = wdf_rdy_rand;

	initial begin
		// Every bit of the word index shows up in the fill
		for (int i = 0; i < 256; i++)
			mem[i] = {8'(i), 8'(~i), 8'(i * 13), 8'(i ^ 165)};
		// Read channel idle from time zero
		app_rd_data       = '0;
		app_rd_data_valid = 1'b0;
	end

	always @(posedge clk) begin
		int due;
		if (rst) begin
			data_q.delete();
			due_q.delete();
			cyc               <= 0;
			last_due          <= 0;
			app_rd_data       <= '0;
			app_rd_data_valid <= 1'b0;
		end else begin
			cyc               <= cyc + 1;
			app_rd_data_valid <= 1'b0;
			// Write lands when command and data are taken together
			if (app_en && app_wr && app_rdy && app_wdf_wren && app_wdf_rdy)
				mem[app_addr[7:0]] <= app_wdf_data;
			// Stalled beats are lost, not delayed
			if (stall) begin
				data_q.delete();
				due_q.delete();
			end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
				app_rd_data_valid <= 1'b1;
				app_rd_data       <= data_q.pop_front();
				void'(due_q.pop_front());
			end
			// Two to five cycles of latency, never overtaking an older beat
			if (app_en && !app_wr && app_rdy && !stall) begin
				due = cyc + 2 + int'(lat_sel);
				if (due < last_due)
					due = last_due;
				last_due <= due;
				due_q.push_back(due);
				data_q.push_back(mem[app_addr[7:0]]);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/mpmc_burst_counter.sv
`default_nettype none

module mpmc_burst_counter (
	input  wire                     clk,
	input  wire                     rst,
	input  mpmc_ctrl_pkg::state_t   state,
	input  wire [1:0]               burst,
	input  wire                     req_beat,
	input  wire                     resp_beat,
	output logic                    req_done,
	output logic                    resp_done
);

	// Up to four beats, so three bits each
	logic [2:0] req_cnt;
	logic [2:0] resp_cnt;
	logic       clear;

	// The write phase of an atomic starts with fresh counts
	assign clear = (state == mpmc_ctrl_pkg::IDLE) || (state == mpmc_ctrl_pkg::WRITE_DATA0);

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			req_cnt  <= '0;
			resp_cnt <= '0;
		end else begin
			if (req_beat)
				req_cnt <= req_cnt + 3'd1;
			if (resp_beat)
				resp_cnt <= resp_cnt + 3'd1;
		end
	end

	// Request count is the index of the beat now on the port
	assign req_done = req_cnt == {1'b0, burst};

	// All beats of the burst have returned
	assign resp_done = resp_cnt == ({1'b0, burst} + 3'd1);

endmodule

`default_nettype wire

//--- verilog/mpmc_cmd_fifo.sv
`default_nettype none

`include "mpmc_params.svh"

module mpmc_cmd_fifo (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  push,
	input  mpmc_bus_pkg::cmd_t   push_cmd,
	input  wire                  pop,
	output mpmc_bus_pkg::cmd_t   head,
	output logic                 valid,
	output logic                 full
);

	localparam int DEPTH = `MPMC_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	mpmc_bus_pkg::cmd_t mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;
	logic               do_push;
	logic               do_pop;

	// A push while full is dropped, a pop while empty is ignored
	assign do_push = push && !full;
	assign do_pop  = pop && valid;

	assign valid = count != '0;
	assign full  = count == DEPTH[PTR_W:0];

	// Head is visible before the pop
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_cmd;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop keep the count
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mpmc_core.sv
`default_nettype none

`include "mpmc_params.svh"

module mpmc_core (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          calib_complete,
	// Command intake
	input  wire                          cmd_valid,
	input  mpmc_bus_pkg::opcode_t        cmd_op,
	input  wire [`MPMC_ADDR_W-1:0]       cmd_addr,
	input  wire [`MPMC_DATA_W-1:0]       cmd_data,
	input  wire [1:0]                    cmd_burst,
	output logic                         cmd_full,
	// Responses
	output logic                         resp_valid,
	output logic [`MPMC_DATA_W-1:0]      resp_data,
	output logic                         timeout_err,
	// Memory application port
	output logic                         app_en,
	output logic                         app_wr,
	output logic [`MPMC_ADDR_W-1:0]      app_addr,
	input  wire                          app_rdy,
	output logic                         app_wdf_wren,
	output logic [`MPMC_DATA_W-1:0]      app_wdf_data,
	input  wire                          app_wdf_rdy,
	input  wire [`MPMC_DATA_W-1:0]       app_rd_data,
	input  wire                          app_rd_data_valid
);

	mpmc_app_if            app_bus ();
	mpmc_bus_pkg::cmd_t    push_cmd;
	mpmc_bus_pkg::cmd_t    head;
	mpmc_bus_pkg::opcode_t cur_op;
	mpmc_ctrl_pkg::state_t state;
	logic                  fifo_v;
	logic                  select_next;
	logic [1:0]            burst;
	logic                  req_beat;
	logic                  resp_beat;
	logic                  req_done;
	logic                  resp_done;
	logic                  to;

	assign push_cmd = '{op: cmd_op, addr: cmd_addr, data: cmd_data, burst: cmd_burst};

	// ========================================
	// Memory side of the application port
	// ========================================
	assign app_en                    = app_bus.app_en;
	assign app_wr                    = app_bus.app_wr;
	assign app_addr                  = app_bus.app_addr;
	assign app_wdf_wren              = app_bus.app_wdf_wren;
	assign app_wdf_data              = app_bus.app_wdf_data;
	assign app_bus.app_rdy           = app_rdy;
	assign app_bus.app_wdf_rdy       = app_wdf_rdy;
	assign app_bus.app_rd_data       = app_rd_data;
	assign app_bus.app_rd_data_valid = app_rd_data_valid;

	mpmc_cmd_fifo u_fifo (
		.clk(clk), .rst(rst), .push(cmd_valid), .push_cmd(push_cmd),
		.pop(select_next), .head(head), .valid(fifo_v), .full(cmd_full)
	);

	mpmc_state_machine u_fsm (
		.clk(clk), .rst(rst), .calib_complete(calib_complete), .fifo_v(fifo_v),
		.cur_op(cur_op), .app(app_bus.ctrl_obs), .req_done(req_done),
		.resp_done(resp_done), .to(to), .state(state),
		.select_next(select_next), .timeout_err(timeout_err)
	);

	mpmc_burst_counter u_burst (
		.clk(clk), .rst(rst), .state(state), .burst(burst), .req_beat(req_beat),
		.resp_beat(resp_beat), .req_done(req_done), .resp_done(resp_done)
	);

	mpmc_timeout_timer u_timer (.clk(clk), .rst(rst), .state(state), .to(to));

	mpmc_datapath u_dp (
		.clk(clk), .rst(rst), .state(state), .select_next(select_next), .head(head),
		.cur_op(cur_op), .burst(burst), .req_beat(req_beat), .resp_beat(resp_beat),
		.resp_valid(resp_valid), .resp_data(resp_data), .app(app_bus.ctrl)
	);

endmodule

`default_nettype wire

//--- verilog/mpmc_state_machine.sv
`default_nettype none

module mpmc_state_machine (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      calib_complete,
	input  wire                      fifo_v,
	input  mpmc_bus_pkg::opcode_t    cur_op,
	mpmc_app_if.ctrl_obs             app,
	input  wire                      req_done,
	input  wire                      resp_done,
	input  wire                      to,
	output mpmc_ctrl_pkg::state_t    state,
	output logic                     select_next,
	output logic                     timeout_err
);

	mpmc_ctrl_pkg::state_t next_state;

	// Fetch happens on the IDLE to PRESET1 step
	assign select_next = (state == mpmc_ctrl_pkg::IDLE) && calib_complete && fifo_v;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= mpmc_ctrl_pkg::IDLE;
			timeout_err <= 1'b0;
		end else begin
			state <= next_state;
			// Timer is quiet in IDLE, so this is a single pulse
			timeout_err <= to && calib_complete;
		end
	end

	// ========================================
	// Next state
	// ========================================
	always_comb begin
		next_state = state;
		case (state)
			mpmc_ctrl_pkg::IDLE:
				if (select_next)
					next_state = mpmc_ctrl_pkg::PRESET1;
			mpmc_ctrl_pkg::PRESET1:
				next_state = mpmc_ctrl_pkg::PRESET2;
			mpmc_ctrl_pkg::PRESET2:
				next_state = mpmc_ctrl_pkg::PRESET3;
			// Stores write directly, loads and atomics read first
			mpmc_ctrl_pkg::PRESET3:
				if (cur_op == mpmc_bus_pkg::CMD_STORE)
					next_state = mpmc_ctrl_pkg::WRITE_DATA0;
				else
					next_state = mpmc_ctrl_pkg::READ_DATA0;
			mpmc_ctrl_pkg::WRITE_DATA0:
				next_state = mpmc_ctrl_pkg::WRITE_DATA1;
			// Command and data go out together
			mpmc_ctrl_pkg::WRITE_DATA1:
				if (app.app_rdy && app.app_wdf_rdy && req_done)
					next_state = mpmc_ctrl_pkg::IDLE;
			// Last beat leaves on the cycle its count matches the burst
			mpmc_ctrl_pkg::READ_DATA0:
				if (app.app_rdy && req_done)
					next_state = mpmc_ctrl_pkg::READ_DATA2;
			// Wait for every beat to come back
			mpmc_ctrl_pkg::READ_DATA2:
				if (resp_done) begin
					if (cur_op == mpmc_bus_pkg::CMD_LOAD)
						next_state = mpmc_ctrl_pkg::WAIT_NACK;
					else
						next_state = mpmc_ctrl_pkg::ALU1;
				end
			mpmc_ctrl_pkg::ALU1:
				next_state = mpmc_ctrl_pkg::ALU2;
			mpmc_ctrl_pkg::ALU2:
				next_state = mpmc_ctrl_pkg::ALU3;
			mpmc_ctrl_pkg::ALU3:
				next_state = mpmc_ctrl_pkg::ALU4;
			mpmc_ctrl_pkg::ALU4:
				next_state = mpmc_ctrl_pkg::WRITE_TRAMP1;
			// Result goes back through the store path
			mpmc_ctrl_pkg::WRITE_TRAMP1:
				next_state = mpmc_ctrl_pkg::WRITE_DATA0;
			mpmc_ctrl_pkg::WAIT_NACK:
				next_state = mpmc_ctrl_pkg::IDLE;
			default:
				next_state = mpmc_ctrl_pkg::IDLE;
		endcase

		// Hung transaction, give up on it
		// Never during calibration
		if (to && calib_complete)
			next_state = mpmc_ctrl_pkg::IDLE;
	end

endmodule

`default_nettype wire

//--- verilog/mpmc_timeout_timer.sv
`default_nettype none

`include "mpmc_params.svh"

module mpmc_timeout_timer (
	input  wire                     clk,
	input  wire                     rst,
	input  mpmc_ctrl_pkg::state_t   state,
	output logic                    to
);

	localparam int CNT_W = $clog2(`MPMC_TIMEOUT + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`MPMC_TIMEOUT);

	logic [CNT_W-1:0] cnt;
	logic             busy;

	assign busy = state != mpmc_ctrl_pkg::IDLE;

	// Counts cycles away from IDLE, holds at the limit
	always_ff @(posedge clk) begin
		if (rst || !busy)
			cnt <= '0;
		else if (cnt != LIMIT)
			cnt <= cnt + 1'b1;
	end

	// Gated by busy so the first IDLE cycle after a hang stays quiet
	assign to = busy && (cnt == LIMIT);

endmodule

`default_nettype wire
